/* Makefile */
FILELIST = fme_buf.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f $(FILELIST) --top-module fme_buf_top

sim:
	verilator --binary --timing --assert -f $(FILELIST) --top-module tb_fme_buf \
		-Mdir obj_dir -o tb_fme_buf
	./obj_dir/tb_fme_buf | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* fme_buf.f */
fme_buf_pkg.sv
fme_buf_ram.sv
fme_buf_rot_decode.sv
fme_mv_bank_exec.sv
fme_mv_rd_result.sv
fme_pred_pingpong.sv
fme_buf_top.sv
tb_fme_buf.sv

/* fme_buf_pkg.sv */
// fme buffer package with widths, depths, bank roles and rotation arithmetic
package fme_buf_pkg;

  // --------------------
  // motion vectors
  localparam int FMV_W    = 10;
  localparam int MV_W     = 2 * FMV_W;
  localparam int MV_DEPTH = 64;
  localparam int MV_AW    = $clog2(MV_DEPTH);

  // --------------------
  // prediction lines
  localparam int PIXEL_W    = 8;
  localparam int PRED_PELS  = 32;
  localparam int PRED_W     = PRED_PELS * PIXEL_W;
  localparam int PRED_DEPTH = 32;
  localparam int PRED_AW    = $clog2(PRED_DEPTH);

  // --------------------
  // rotation
  localparam int MV_BANKS = 3;
  localparam int ROT_W    = 2;

  // encoding doubles as the bank offset from the rotation index
  typedef enum logic [1:0] {
    ROLE_FME = 2'd0,
    ROLE_DB  = 2'd1,
    ROLE_MC  = 2'd2
  } bank_role_e;

  // (a + b) mod 3, both inputs below 3
  function automatic logic [ROT_W-1:0] rot_add(
    input logic [ROT_W-1:0] a,
    input logic [ROT_W-1:0] b
  );
    logic [ROT_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    if (sum >= (ROT_W+1)'(MV_BANKS)) begin
      sum = sum - (ROT_W+1)'(MV_BANKS);
    end
    return sum[ROT_W-1:0];
  endfunction

endpackage

/* fme_buf_ram.sv */
// dual-port RAM with one write port and a registered, read-first read port
module fme_buf_ram #(
  parameter int DATA_W = 8,
  parameter int ADDR_W = 4
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              wr_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic              rd_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // read register holds between reads
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_data_o <= '0;
    end else if (rd_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

/* fme_buf_rot_decode.sv */
// stage rotation counter, ping-pong bit and per-bank role decode
module fme_buf_rot_decode (
  input  logic                                              clk,
  input  logic                                              arst_n_i,
  input  logic                                              stage_advance_i,
  output logic [fme_buf_pkg::ROT_W-1:0]                     rot_o,
  output fme_buf_pkg::bank_role_e [fme_buf_pkg::MV_BANKS-1:0] bank_role_o,
  output logic                                              pred_wr_bank_o
);

  logic [fme_buf_pkg::ROT_W-1:0] rot_q;
  logic                          pred_q;

  // --------------------
  // stage state
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rot_q  <= '0;
      pred_q <= 1'b0;
    end else if (stage_advance_i) begin
      rot_q  <= fme_buf_pkg::rot_add(rot_q, fme_buf_pkg::ROT_W'(1));
      pred_q <= ~pred_q;
    end
  end

  // --------------------
  // role decode
  // role k sits in bank (rot + k) mod 3
  always_comb begin
    for (int b = 0; b < fme_buf_pkg::MV_BANKS; b++) begin
      bank_role_o[b] = fme_buf_pkg::ROLE_FME;
    end
    for (int k = 0; k < fme_buf_pkg::MV_BANKS; k++) begin
      bank_role_o[fme_buf_pkg::rot_add(rot_q, fme_buf_pkg::ROT_W'(k))] =
        fme_buf_pkg::bank_role_e'(k);
    end
  end

  assign rot_o          = rot_q;
  assign pred_wr_bank_o = pred_q;

  // counter wraps before reaching 3
  a_rot_range: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    rot_q != fme_buf_pkg::ROT_W'(3)
  );

endmodule

/* fme_buf_top.sv */
// FME buffer shell with rotating MV banks and ping-pong prediction banks
module fme_buf_top (
  input  logic                                clk,
  input  logic                                arst_n_i,
  input  logic                                stage_advance_i,
  // fme mv write
  input  logic                                fme_mv_wr_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]       fme_mv_wr_addr_i,
  input  logic [fme_buf_pkg::MV_W-1:0]        fme_mv_wr_data_i,
  // mv reads
  input  logic                                fme_mv_rd_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]       fme_mv_rd_addr_i,
  output logic [fme_buf_pkg::MV_W-1:0]        fme_mv_rd_data_o,
  input  logic                                mc_mv_rd_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]       mc_mv_rd_addr_i,
  output logic [fme_buf_pkg::MV_W-1:0]        mc_mv_rd_data_o,
  input  logic                                db_mv_rd_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]       db_mv_rd_addr_i,
  output logic [fme_buf_pkg::MV_W-1:0]        db_mv_rd_data_o,
  // prediction lines
  input  logic                                fme_pred_wr_i,
  input  logic [fme_buf_pkg::PRED_AW-1:0]     fme_pred_wr_addr_i,
  input  logic [fme_buf_pkg::PRED_W-1:0]      fme_pred_wr_data_i,
  input  logic                                mc_pred_rd_i,
  input  logic [fme_buf_pkg::PRED_AW-1:0]     mc_pred_rd_addr_i,
  output logic [fme_buf_pkg::PRED_W-1:0]      mc_pred_rd_data_o
);

  logic [fme_buf_pkg::ROT_W-1:0]                            rot_w;
  fme_buf_pkg::bank_role_e [fme_buf_pkg::MV_BANKS-1:0]      bank_role_w;
  logic                                                     pred_wr_bank_w;
  logic [fme_buf_pkg::MV_BANKS-1:0][fme_buf_pkg::MV_W-1:0]  bank_rd_data_w;

  fme_buf_rot_decode u_rot_decode (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .stage_advance_i (stage_advance_i),
    .rot_o           (rot_w),
    .bank_role_o     (bank_role_w),
    .pred_wr_bank_o  (pred_wr_bank_w)
  );

  fme_mv_bank_exec u_mv_bank_exec (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .bank_role_i      (bank_role_w),
    .fme_mv_wr_i      (fme_mv_wr_i),
    .fme_mv_wr_addr_i (fme_mv_wr_addr_i),
    .fme_mv_wr_data_i (fme_mv_wr_data_i),
    .fme_mv_rd_i      (fme_mv_rd_i),
    .fme_mv_rd_addr_i (fme_mv_rd_addr_i),
    .mc_mv_rd_i       (mc_mv_rd_i),
    .mc_mv_rd_addr_i  (mc_mv_rd_addr_i),
    .db_mv_rd_i       (db_mv_rd_i),
    .db_mv_rd_addr_i  (db_mv_rd_addr_i),
    .bank_rd_data_o   (bank_rd_data_w)
  );

  fme_mv_rd_result u_mv_rd_result (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .rot_i            (rot_w),
    .fme_mv_rd_i      (fme_mv_rd_i),
    .mc_mv_rd_i       (mc_mv_rd_i),
    .db_mv_rd_i       (db_mv_rd_i),
    .bank_rd_data_i   (bank_rd_data_w),
    .fme_mv_rd_data_o (fme_mv_rd_data_o),
    .mc_mv_rd_data_o  (mc_mv_rd_data_o),
    .db_mv_rd_data_o  (db_mv_rd_data_o)
  );

  fme_pred_pingpong u_pred_pingpong (
    .clk                (clk),
    .arst_n_i           (arst_n_i),
    .pred_wr_bank_i     (pred_wr_bank_w),
    .fme_pred_wr_i      (fme_pred_wr_i),
    .fme_pred_wr_addr_i (fme_pred_wr_addr_i),
    .fme_pred_wr_data_i (fme_pred_wr_data_i),
    .mc_pred_rd_i       (mc_pred_rd_i),
    .mc_pred_rd_addr_i  (mc_pred_rd_addr_i),
    .mc_pred_rd_data_o  (mc_pred_rd_data_o)
  );

endmodule

/* fme_mv_bank_exec.sv */
// three MV banks with write and read port steering by bank role
module fme_mv_bank_exec (
  input  logic                                              clk,
  input  logic                                              arst_n_i,
  input  fme_buf_pkg::bank_role_e [fme_buf_pkg::MV_BANKS-1:0] bank_role_i,
  // fme write
  input  logic                                              fme_mv_wr_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]                     fme_mv_wr_addr_i,
  input  logic [fme_buf_pkg::MV_W-1:0]                      fme_mv_wr_data_i,
  // reads
  input  logic                                              fme_mv_rd_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]                     fme_mv_rd_addr_i,
  input  logic                                              mc_mv_rd_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]                     mc_mv_rd_addr_i,
  input  logic                                              db_mv_rd_i,
  input  logic [fme_buf_pkg::MV_AW-1:0]                     db_mv_rd_addr_i,
  output logic [fme_buf_pkg::MV_BANKS-1:0][fme_buf_pkg::MV_W-1:0] bank_rd_data_o
);

  // --------------------
  // per-bank steering
  for (genvar b = 0; b < fme_buf_pkg::MV_BANKS; b++) begin : g_bank
    logic                          wr_en;
    logic                          rd_en;
    logic [fme_buf_pkg::MV_AW-1:0] rd_addr;

    always_comb begin
      wr_en   = 1'b0;
      rd_en   = 1'b0;
      rd_addr = '0;
      case (bank_role_i[b])
        fme_buf_pkg::ROLE_FME: begin
          wr_en   = fme_mv_wr_i;
          rd_en   = fme_mv_rd_i;
          rd_addr = fme_mv_rd_addr_i;
        end
        fme_buf_pkg::ROLE_MC: begin
          rd_en   = mc_mv_rd_i;
          rd_addr = mc_mv_rd_addr_i;
        end
        fme_buf_pkg::ROLE_DB: begin
          rd_en   = db_mv_rd_i;
          rd_addr = db_mv_rd_addr_i;
        end
        default: begin
          rd_en = 1'b0;
        end
      endcase
    end

    // write address and data go to all banks, only the enable is steered
    fme_buf_ram #(
      .DATA_W (fme_buf_pkg::MV_W),
      .ADDR_W (fme_buf_pkg::MV_AW)
    ) u_mv_ram (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .wr_i      (wr_en),
      .wr_addr_i (fme_mv_wr_addr_i),
      .wr_data_i (fme_mv_wr_data_i),
      .rd_i      (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (bank_rd_data_o[b])
    );
  end

  // --------------------
  // role check
  for (genvar k = 0; k < fme_buf_pkg::MV_BANKS; k++) begin : g_role_chk
    logic [fme_buf_pkg::MV_BANKS-1:0] hit;

    for (genvar b = 0; b < fme_buf_pkg::MV_BANKS; b++) begin : g_hit
      assign hit[b] = (bank_role_i[b] == fme_buf_pkg::bank_role_e'(k));
    end

    // decode upstream must hand out every role exactly once
    a_role_once: assert property (
      @(posedge clk) disable iff (!arst_n_i)
      $onehot(hit)
    );
  end

endmodule

/* fme_mv_rd_result.sv */
// returns each MV bank read to the port that owned the bank at issue
module fme_mv_rd_result (
  input  logic                                              clk,
  input  logic                                              arst_n_i,
  input  logic [fme_buf_pkg::ROT_W-1:0]                     rot_i,
  input  logic                                              fme_mv_rd_i,
  input  logic                                              mc_mv_rd_i,
  input  logic                                              db_mv_rd_i,
  input  logic [fme_buf_pkg::MV_BANKS-1:0][fme_buf_pkg::MV_W-1:0] bank_rd_data_i,
  output logic [fme_buf_pkg::MV_W-1:0]                      fme_mv_rd_data_o,
  output logic [fme_buf_pkg::MV_W-1:0]                      mc_mv_rd_data_o,
  output logic [fme_buf_pkg::MV_W-1:0]                      db_mv_rd_data_o
);

  logic [fme_buf_pkg::MV_BANKS-1:0]                         rd_issue;
  logic [fme_buf_pkg::MV_BANKS-1:0]                         rd_q;
  logic [fme_buf_pkg::ROT_W-1:0]                            rot_q;
  logic [fme_buf_pkg::MV_BANKS-1:0][fme_buf_pkg::MV_W-1:0]  port_data;
  logic [fme_buf_pkg::MV_BANKS-1:0][fme_buf_pkg::MV_W-1:0]  hold_q;

  // indexed by role, FME / DB / MC
  assign rd_issue = {mc_mv_rd_i, db_mv_rd_i, fme_mv_rd_i};

  // rotation and strobes of the issue cycle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rot_q  <= '0;
      rd_q   <= '0;
      hold_q <= '0;
    end else begin
      rot_q  <= rot_i;
      rd_q   <= rd_issue;
      hold_q <= port_data;
    end
  end

  // --------------------
  // per-port steering
  for (genvar k = 0; k < fme_buf_pkg::MV_BANKS; k++) begin : g_port
    logic [fme_buf_pkg::ROT_W-1:0] bank_sel;

    assign bank_sel     = fme_buf_pkg::rot_add(rot_q, fme_buf_pkg::ROT_W'(k));
    // fresh data on the return cycle, otherwise keep the last value
    assign port_data[k] = rd_q[k] ? bank_rd_data_i[bank_sel] : hold_q[k];
  end

  assign fme_mv_rd_data_o = port_data[fme_buf_pkg::ROLE_FME];
  assign mc_mv_rd_data_o  = port_data[fme_buf_pkg::ROLE_MC];
  assign db_mv_rd_data_o  = port_data[fme_buf_pkg::ROLE_DB];

endmodule

/* fme_pred_pingpong.sv */
// two prediction-line banks, FME writes one while MC reads the other
module fme_pred_pingpong (
  input  logic                                clk,
  input  logic                                arst_n_i,
  input  logic                                pred_wr_bank_i,
  input  logic                                fme_pred_wr_i,
  input  logic [fme_buf_pkg::PRED_AW-1:0]     fme_pred_wr_addr_i,
  input  logic [fme_buf_pkg::PRED_W-1:0]      fme_pred_wr_data_i,
  input  logic                                mc_pred_rd_i,
  input  logic [fme_buf_pkg::PRED_AW-1:0]     mc_pred_rd_addr_i,
  output logic [fme_buf_pkg::PRED_W-1:0]      mc_pred_rd_data_o
);

  logic [1:0]                          wr_en;
  logic [1:0]                          rd_en;
  logic [1:0][fme_buf_pkg::PRED_W-1:0] bank_rd_data;
  logic                                rd_bank_q;

  // --------------------
  // banks
  for (genvar b = 0; b < 2; b++) begin : g_bank
    assign wr_en[b] = fme_pred_wr_i && (pred_wr_bank_i == 1'(b));
    assign rd_en[b] = mc_pred_rd_i && (pred_wr_bank_i != 1'(b));

    fme_buf_ram #(
      .DATA_W (fme_buf_pkg::PRED_W),
      .ADDR_W (fme_buf_pkg::PRED_AW)
    ) u_pred_ram (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .wr_i      (wr_en[b]),
      .wr_addr_i (fme_pred_wr_addr_i),
      .wr_data_i (fme_pred_wr_data_i),
      .rd_i      (rd_en[b]),
      .rd_addr_i (mc_pred_rd_addr_i),
      .rd_data_o (bank_rd_data[b])
    );
  end

  // --------------------
  // read return
  // bank bit captured at issue, so a read on the strobe cycle still
  // returns the bank it addressed
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_bank_q <= 1'b0;
    end else if (mc_pred_rd_i) begin
      rd_bank_q <= ~pred_wr_bank_i;
    end
  end

  assign mc_pred_rd_data_o = bank_rd_data[rd_bank_q];

  a_no_wr_rd_same_bank: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (wr_en & rd_en) == 2'b00
  );

endmodule

/* tb_fme_buf.sv */
// testbench for the FME buffer shell checking every read against a stage-aged model
module tb_fme_buf;

  localparam int NUM_STAGES = 6;
  localparam int NUM_ADDR   = 16;
  localparam int TIMEOUT    = 20;

  logic                               clk;
  logic                               arst_n_i;
  logic                               stage_advance_i;
  logic                               fme_mv_wr_i;
  logic [fme_buf_pkg::MV_AW-1:0]      fme_mv_wr_addr_i;
  logic [fme_buf_pkg::MV_W-1:0]       fme_mv_wr_data_i;
  logic                               fme_mv_rd_i;
  logic [fme_buf_pkg::MV_AW-1:0]      fme_mv_rd_addr_i;
  logic [fme_buf_pkg::MV_W-1:0]       fme_mv_rd_data_o;
  logic                               mc_mv_rd_i;
  logic [fme_buf_pkg::MV_AW-1:0]      mc_mv_rd_addr_i;
  logic [fme_buf_pkg::MV_W-1:0]       mc_mv_rd_data_o;
  logic                               db_mv_rd_i;
  logic [fme_buf_pkg::MV_AW-1:0]      db_mv_rd_addr_i;
  logic [fme_buf_pkg::MV_W-1:0]       db_mv_rd_data_o;
  logic                               fme_pred_wr_i;
  logic [fme_buf_pkg::PRED_AW-1:0]    fme_pred_wr_addr_i;
  logic [fme_buf_pkg::PRED_W-1:0]     fme_pred_wr_data_i;
  logic                               mc_pred_rd_i;
  logic [fme_buf_pkg::PRED_AW-1:0]    mc_pred_rd_addr_i;
  logic [fme_buf_pkg::PRED_W-1:0]     mc_pred_rd_data_o;

  // reference model with one array per stage of age (0 = FME, 1 = MC, 2 = DB)
  logic [fme_buf_pkg::MV_W-1:0]   mv_age0 [fme_buf_pkg::MV_DEPTH];
  logic [fme_buf_pkg::MV_W-1:0]   mv_age1 [fme_buf_pkg::MV_DEPTH];
  logic [fme_buf_pkg::MV_W-1:0]   mv_age2 [fme_buf_pkg::MV_DEPTH];
  logic [fme_buf_pkg::MV_W-1:0]   mv_tmp  [fme_buf_pkg::MV_DEPTH];
  logic [fme_buf_pkg::PRED_W-1:0] pred_age0 [fme_buf_pkg::PRED_DEPTH];
  logic [fme_buf_pkg::PRED_W-1:0] pred_age1 [fme_buf_pkg::PRED_DEPTH];
  logic [fme_buf_pkg::PRED_W-1:0] pred_tmp  [fme_buf_pkg::PRED_DEPTH];

  logic [fme_buf_pkg::MV_W-1:0]   exp_fme_mv, exp_mc_mv, exp_db_mv;
  logic [fme_buf_pkg::MV_W-1:0]   exp_fme_q, exp_mc_q, exp_db_q;
  logic [fme_buf_pkg::PRED_W-1:0] exp_pred, exp_pred_q;
  logic [3:0]                     rd_q;
  logic                           rd_seen;
  logic                           timed_out;
  int seed         = 84;
  int err_mv       = 0;
  int err_pred     = 0;
  int err_rst      = 0;
  int reads_issued = 0;
  int checks_done  = 0;

  fme_buf_top u_fme_buf_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // expected value of the last read on each port
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_q        <= '0;
      checks_done <= 0;
      exp_fme_q   <= '0;
      exp_mc_q    <= '0;
      exp_db_q    <= '0;
      exp_pred_q  <= '0;
    end else begin
      rd_q        <= {fme_mv_rd_i, mc_mv_rd_i, db_mv_rd_i, mc_pred_rd_i};
      checks_done <= checks_done + $countones(rd_q);
      if (fme_mv_rd_i) begin
        exp_fme_q <= exp_fme_mv;
      end
      if (mc_mv_rd_i) begin
        exp_mc_q <= exp_mc_mv;
      end
      if (db_mv_rd_i) begin
        exp_db_q <= exp_db_mv;
      end
      if (mc_pred_rd_i) begin
        exp_pred_q <= exp_pred;
      end
    end
  end

  // --------------------
  // checks
  a_reset_zero: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !rd_seen |-> (fme_mv_rd_data_o == '0 && mc_mv_rd_data_o == '0 &&
                  db_mv_rd_data_o == '0 && mc_pred_rd_data_o == '0)
  ) else begin
    err_rst = err_rst + 1;
    $display("[FAIL] outputs after reset, expected 0: fme_mv_rd_data_o=%0h mc_mv_rd_data_o=%0h",
             $sampled(fme_mv_rd_data_o), $sampled(mc_mv_rd_data_o));
    $display("[FAIL] outputs after reset, expected 0: db_mv_rd_data_o=%0h mc_pred_rd_data_o=%0h",
             $sampled(db_mv_rd_data_o), $sampled(mc_pred_rd_data_o));
  end

  // each output follows the last read on its port and holds in between
  a_fme_mv_rd: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    fme_mv_rd_data_o == exp_fme_q
  ) else begin
    err_mv = err_mv + 1;
    $display("[FAIL] fme_mv_rd_data_o expected %0h got %0h",
             $sampled(exp_fme_q), $sampled(fme_mv_rd_data_o));
  end

  a_mc_mv_rd: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    mc_mv_rd_data_o == exp_mc_q
  ) else begin
    err_mv = err_mv + 1;
    $display("[FAIL] mc_mv_rd_data_o expected %0h got %0h",
             $sampled(exp_mc_q), $sampled(mc_mv_rd_data_o));
  end

  a_db_mv_rd: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    db_mv_rd_data_o == exp_db_q
  ) else begin
    err_mv = err_mv + 1;
    $display("[FAIL] db_mv_rd_data_o expected %0h got %0h",
             $sampled(exp_db_q), $sampled(db_mv_rd_data_o));
  end

  a_mc_pred_rd: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    mc_pred_rd_data_o == exp_pred_q
  ) else begin
    err_pred = err_pred + 1;
    $display("[FAIL] mc_pred_rd_data_o expected %0h got %0h",
             $sampled(exp_pred_q), $sampled(mc_pred_rd_data_o));
  end

  // --------------------
  // stimulus helpers
  function automatic logic [fme_buf_pkg::MV_AW-1:0] rand_addr();
    return fme_buf_pkg::MV_AW'($unsigned($random(seed)) % NUM_ADDR);
  endfunction

  function automatic logic [fme_buf_pkg::PRED_W-1:0] rand_line();
    logic [fme_buf_pkg::PRED_W-1:0] line;
    line = '0;
    for (int j = 0; j < fme_buf_pkg::PRED_W / 32; j++) begin
      line = {line[fme_buf_pkg::PRED_W-33:0], 32'($random(seed))};
    end
    return line;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #5;
    stage_advance_i = 1'b0;
    fme_mv_wr_i     = 1'b0;
    fme_mv_rd_i     = 1'b0;
    mc_mv_rd_i      = 1'b0;
    db_mv_rd_i      = 1'b0;
    fme_pred_wr_i   = 1'b0;
    mc_pred_rd_i    = 1'b0;
  endtask

  task automatic issue_fme_mv_rd(input logic [fme_buf_pkg::MV_AW-1:0] addr);
    fme_mv_rd_i      = 1'b1;
    fme_mv_rd_addr_i = addr;
    exp_fme_mv       = mv_age0[addr];
    rd_seen          = 1'b1;
    reads_issued++;
  endtask

  // MC and DB MV reads plus the MC prediction read gated by how many stages hold data
  task automatic issue_aged_reads(input int stage);
    logic [fme_buf_pkg::MV_AW-1:0]   a_mc;
    logic [fme_buf_pkg::MV_AW-1:0]   a_db;
    logic [fme_buf_pkg::PRED_AW-1:0] a_pred;
    a_mc   = rand_addr();
    a_db   = rand_addr();
    a_pred = fme_buf_pkg::PRED_AW'(rand_addr());
    if (stage >= 1) begin
      mc_mv_rd_i        = 1'b1;
      mc_mv_rd_addr_i   = a_mc;
      exp_mc_mv         = mv_age1[a_mc];
      mc_pred_rd_i      = 1'b1;
      mc_pred_rd_addr_i = a_pred;
      exp_pred          = pred_age1[a_pred];
      rd_seen           = 1'b1;
      reads_issued      = reads_issued + 2;
    end
    if (stage >= 2) begin
      db_mv_rd_i      = 1'b1;
      db_mv_rd_addr_i = a_db;
      exp_db_mv       = mv_age2[a_db];
      reads_issued++;
    end
  endtask

  task automatic write_entry(input int idx);
    logic [fme_buf_pkg::MV_W-1:0]   mv;
    logic [fme_buf_pkg::PRED_W-1:0] line;
    mv                 = fme_buf_pkg::MV_W'($random(seed));
    line               = rand_line();
    fme_mv_wr_i        = 1'b1;
    fme_mv_wr_addr_i   = fme_buf_pkg::MV_AW'(idx);
    fme_mv_wr_data_i   = mv;
    mv_age0[idx]       = mv;
    fme_pred_wr_i      = 1'b1;
    fme_pred_wr_addr_i = fme_buf_pkg::PRED_AW'(idx);
    fme_pred_wr_data_i = line;
    pred_age0[idx]     = line;
  endtask

  task automatic advance_model();
    mv_tmp    = mv_age2;
    mv_age2   = mv_age1;
    mv_age1   = mv_age0;
    // bank coming back to FME keeps what DB saw
    mv_age0   = mv_tmp;
    pred_tmp  = pred_age1;
    pred_age1 = pred_age0;
    pred_age0 = pred_tmp;
  endtask

  task automatic wait_checks();
    int n;
    n = 0;
    while (checks_done != reads_issued && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (checks_done != reads_issued) begin
      $display("read results did not all come back within %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_stage(input int stage);
    for (int i = 0; i < NUM_ADDR; i++) begin
      next_cycle();
      // reads before the write so expected values predate it
      if (i > 0) begin
        issue_fme_mv_rd(fme_buf_pkg::MV_AW'(i - 1));
      end
      issue_aged_reads(stage);
      write_entry(i);
    end
    // reads on the strobe cycle still belong to the old roles
    next_cycle();
    stage_advance_i = 1'b1;
    issue_fme_mv_rd(rand_addr());
    issue_aged_reads(stage);
    advance_model();
    next_cycle();
    wait_checks();
  endtask

  task automatic wrap_up();
    $display("errors: mv %0d, pred %0d, reset %0d, timeout %0d",
             err_mv, err_pred, err_rst, timed_out);
    if (err_mv == 0 && err_pred == 0 && err_rst == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // --------------------
  // main sequence
  initial begin
    arst_n_i           = 1'b0;
    stage_advance_i    = 1'b0;
    fme_mv_wr_i        = 1'b0;
    fme_mv_wr_addr_i   = '0;
    fme_mv_wr_data_i   = '0;
    fme_mv_rd_i        = 1'b0;
    fme_mv_rd_addr_i   = '0;
    mc_mv_rd_i         = 1'b0;
    mc_mv_rd_addr_i    = '0;
    db_mv_rd_i         = 1'b0;
    db_mv_rd_addr_i    = '0;
    fme_pred_wr_i      = 1'b0;
    fme_pred_wr_addr_i = '0;
    fme_pred_wr_data_i = '0;
    mc_pred_rd_i       = 1'b0;
    mc_pred_rd_addr_i  = '0;
    exp_fme_mv         = '0;
    exp_mc_mv          = '0;
    exp_db_mv          = '0;
    exp_pred           = '0;
    rd_seen            = 1'b0;
    timed_out          = 1'b0;
    repeat (8) @(posedge clk);
    #5;
    arst_n_i = 1'b1;
    // idle cycles with outputs still at zero
    repeat (3) next_cycle();
    for (int s = 0; s < NUM_STAGES && !timed_out; s++) begin
      run_stage(s);
    end
    wrap_up();
  end

endmodule
